/* include/regRead_params.svh */
`ifndef REGREAD_PARAMS_SVH
`define REGREAD_PARAMS_SVH

// Issue width, also the number of write-back lanes
`define RR_LANES 4

// Physical register file
`define RR_PHYS_REGS 64
`define RR_TAG_W 6
`define RR_DATA_W 32

// Branch speculation
`define RR_CHECKPOINTS 4
`define RR_CKPT_W 2

// Registers holding committed architectural state out of reset
`define RR_ARCH_REGS 32

// Opaque instruction fields carried alongside each lane
`define RR_PAYLOAD_W 16

`endif

/* logic/regTypesPkg.sv */
`default_nettype none
`include "regRead_params.svh"

package regTypesPkg;

  typedef logic [`RR_TAG_W-1:0]     regTag_t;     // Physical register number
  typedef logic [`RR_DATA_W-1:0]    regData_t;    // Operand value
  typedef logic [`RR_PAYLOAD_W-1:0] payload_t;    // Passes through untouched
  typedef logic [`RR_PHYS_REGS-1:0] readyVec_t;   // One bit per register

  typedef logic [$clog2(`RR_LANES)-1:0] laneIdx_t;

endpackage

`default_nettype wire

/* logic/branchPkg.sv */
`default_nettype none
`include "regRead_params.svh"

package branchPkg;

  typedef logic [`RR_CHECKPOINTS-1:0] branchMask_t;  // Unresolved branches ahead
  typedef logic [`RR_CKPT_W-1:0]      ckptId_t;      // Branch being resolved

endpackage

`default_nettype wire

/* logic/wbBus_if.sv */
`timescale 1ns/100ps
`default_nettype none
`include "regRead_params.svh"

// Write-back results, one strobe per lane per cycle
interface wbBus_if;

  logic                  wrValid [`RR_LANES];
  regTypesPkg::regTag_t  wrDest  [`RR_LANES];
  regTypesPkg::regData_t wrData  [`RR_LANES];

  modport src
  (
    output wrValid,
    output wrDest,
    output wrData
  );

  modport rf
  (
    input wrValid,
    input wrDest,
    input wrData
  );

  modport fwd
  (
    input wrValid,
    input wrDest,
    input wrData
  );

endinterface

`default_nettype wire

/* logic/squashFilter.sv */
`timescale 1ns/100ps
`default_nettype none
`include "regRead_params.svh"

module squashFilter
(
  input  logic                   clk,
  input  logic                   fuValid_i      [`RR_LANES],
  input  branchPkg::branchMask_t branchMask_i   [`RR_LANES],
  input  logic                   ctrlVerified_i,
  input  logic                   ctrlMispredict_i,
  input  branchPkg::ckptId_t     ctrlCkpt_i,
  output logic                   laneLive_o     [`RR_LANES]
);

  logic mispredict;

  assign mispredict = ctrlVerified_i & ctrlMispredict_i;  // Only resolved branches squash

  always_comb
  begin
    for (int l = 0; l < `RR_LANES; l++)
    begin
      laneLive_o[l] = fuValid_i[l] & ~(mispredict & branchMask_i[l][ctrlCkpt_i]);
    end
  end

  for (genvar l = 0; l < `RR_LANES; l++)
  begin : gLaneChk
    // A squash may only drop a lane, never create one
    assert property (@(posedge clk) laneLive_o[l] |-> fuValid_i[l]);
  end

endmodule

`default_nettype wire

/* logic/physRegFile.sv */
`timescale 1ns/100ps
`default_nettype none
`include "regRead_params.svh"

// Four write ports, eight read ports
module physRegFile
(
  input  logic                  clk,
  input  logic                  recoverFlag_i,
  wbBus_if.rf                   wb,
  input  regTypesPkg::regTag_t  rdTag_i  [2*`RR_LANES],
  output regTypesPkg::regData_t rdData_o [2*`RR_LANES]
);

  regTypesPkg::regData_t regMem [`RR_PHYS_REGS];
  logic                  wrEn   [`RR_LANES];

  always_comb
  begin
    for (int l = 0; l < `RR_LANES; l++)
    begin
      wrEn[l] = wb.wrValid[l] & ~recoverFlag_i;  // Results on a wrong path are dropped
    end
  end

  // Lanes are applied in order, so the highest lane wins a tag collision
  always_ff @(posedge clk)
  begin
    for (int l = 0; l < `RR_LANES; l++)
    begin
      if (wrEn[l])
      begin
        regMem[wb.wrDest[l]] <= wb.wrData[l];
      end
    end
  end

  // Reads see the old contents; same-cycle writes are handled by forwarding
  always_comb
  begin
    for (int r = 0; r < 2*`RR_LANES; r++)
    begin
      rdData_o[r] = regMem[rdTag_i[r]];
    end
  end

endmodule

`default_nettype wire

/* logic/operandSelect.sv */
`timescale 1ns/100ps
`default_nettype none
`include "regRead_params.svh"

module operandSelect
(
  input  logic                  clk,
  input  logic                  rst_i,
  wbBus_if.fwd                  wb,
  input  logic                  laneLive_i [`RR_LANES],
  input  regTypesPkg::regTag_t  srcTag_i   [2*`RR_LANES],
  input  regTypesPkg::regData_t rfData_i   [2*`RR_LANES],
  input  regTypesPkg::regTag_t  destTag_i  [`RR_LANES],
  input  regTypesPkg::payload_t payload_i  [`RR_LANES],
  output logic                  fuValid_o  [`RR_LANES],
  output regTypesPkg::regData_t srcData_o  [2*`RR_LANES],
  output regTypesPkg::regTag_t  destTag_o  [`RR_LANES],
  output regTypesPkg::payload_t payload_o  [`RR_LANES]
);

  logic                  fwdHit  [2*`RR_LANES];
  regTypesPkg::laneIdx_t fwdLane [2*`RR_LANES];
  regTypesPkg::regData_t srcData [2*`RR_LANES];

  // Tag match against every write-back lane, later lanes override
  always_comb
  begin
    for (int s = 0; s < 2*`RR_LANES; s++)
    begin
      fwdHit[s]  = 1'b0;
      fwdLane[s] = '0;
      for (int l = 0; l < `RR_LANES; l++)
      begin
        if (wb.wrValid[l] && (wb.wrDest[l] == srcTag_i[s]))
        begin
          fwdHit[s]  = 1'b1;
          fwdLane[s] = regTypesPkg::laneIdx_t'(l);
        end
      end
    end
  end

  always_comb
  begin
    for (int s = 0; s < 2*`RR_LANES; s++)
    begin
      srcData[s] = fwdHit[s] ? wb.wrData[fwdLane[s]] : rfData_i[s];
    end
  end

  always_ff @(posedge clk)
  begin
    for (int l = 0; l < `RR_LANES; l++)
    begin
      if (rst_i)
      begin
        fuValid_o[l] <= 1'b0;
      end
      else
      begin
        fuValid_o[l] <= laneLive_i[l];
      end
    end
  end

  // Payload side of the output register
  always_ff @(posedge clk)
  begin
    for (int s = 0; s < 2*`RR_LANES; s++)
    begin
      srcData_o[s] <= srcData[s];
    end
    for (int l = 0; l < `RR_LANES; l++)
    begin
      destTag_o[l] <= destTag_i[l];
      payload_o[l] <= payload_i[l];
    end
  end

  for (genvar l = 0; l < `RR_LANES; l++)
  begin : gRstChk
    assert property (@(posedge clk) rst_i |=> !fuValid_o[l]);
  end

endmodule

`default_nettype wire

/* logic/readyTable.sv */
`timescale 1ns/100ps
`default_nettype none
`include "regRead_params.svh"

// Operand ready bits consulted by the issue queue
module readyTable
(
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   exceptionFlag_i,
  input  logic                   unmapValid_i [`RR_LANES],
  input  regTypesPkg::regTag_t   unmapTag_i   [`RR_LANES],
  input  logic                   wakeValid_i  [`RR_LANES],
  input  regTypesPkg::regTag_t   wakeTag_i    [`RR_LANES],
  output regTypesPkg::readyVec_t phyRegRdy_o
);

  localparam regTypesPkg::readyVec_t archReady =
    {{(`RR_PHYS_REGS-`RR_ARCH_REGS){1'b0}}, {`RR_ARCH_REGS{1'b1}}};

  regTypesPkg::readyVec_t readyNext;

  always_comb
  begin
    readyNext = phyRegRdy_o;
    for (int l = 0; l < `RR_LANES; l++)
    begin
      if (unmapValid_i[l])
      begin
        readyNext[unmapTag_i[l]] = 1'b0;
      end
    end
    // Wake-up applied last so a set beats a clear
    for (int l = 0; l < `RR_LANES; l++)
    begin
      if (wakeValid_i[l])
      begin
        readyNext[wakeTag_i[l]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst_i || exceptionFlag_i)
    begin
      phyRegRdy_o <= archReady;  // Only committed mappings survive a flush
    end
    else
    begin
      phyRegRdy_o <= readyNext;
    end
  end

  for (genvar l = 0; l < `RR_LANES; l++)
  begin : gWakeChk
    assert property (@(posedge clk)
      wakeValid_i[l] && !rst_i && !exceptionFlag_i |=> phyRegRdy_o[$past(wakeTag_i[l])]);
  end

endmodule

`default_nettype wire

/* logic/regReadStage.sv */
`timescale 1ns/100ps
`default_nettype none
`include "regRead_params.svh"

module regReadStage
(
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   recoverFlag_i,
  input  logic                   exceptionFlag_i,
  input  logic                   ctrlVerified_i,
  input  logic                   ctrlMispredict_i,
  input  branchPkg::ckptId_t     ctrlCkpt_i,
  // Issue lanes
  input  logic                   fuValid_i    [`RR_LANES],
  input  branchPkg::branchMask_t branchMask_i [`RR_LANES],
  input  regTypesPkg::regTag_t   src1Tag_i    [`RR_LANES],
  input  regTypesPkg::regTag_t   src2Tag_i    [`RR_LANES],
  input  regTypesPkg::regTag_t   destTag_i    [`RR_LANES],
  input  regTypesPkg::payload_t  payload_i    [`RR_LANES],
  // Write-back lanes
  input  logic                   wbValid_i    [`RR_LANES],
  input  regTypesPkg::regTag_t   wbDest_i     [`RR_LANES],
  input  regTypesPkg::regData_t  wbData_i     [`RR_LANES],
  // Ready-table updates
  input  logic                   unmapValid_i [`RR_LANES],
  input  regTypesPkg::regTag_t   unmapTag_i   [`RR_LANES],
  input  logic                   wakeValid_i  [`RR_LANES],
  input  regTypesPkg::regTag_t   wakeTag_i    [`RR_LANES],
  // To the functional units
  output logic                   fuValid_o    [`RR_LANES],
  output regTypesPkg::regData_t  src1Data_o   [`RR_LANES],
  output regTypesPkg::regData_t  src2Data_o   [`RR_LANES],
  output regTypesPkg::regTag_t   destTag_o    [`RR_LANES],
  output regTypesPkg::payload_t  payload_o    [`RR_LANES],
  output regTypesPkg::readyVec_t phyRegRdy_o
);

  wbBus_if wb ();

  logic                  laneLive [`RR_LANES];
  regTypesPkg::regTag_t  srcTag   [2*`RR_LANES];
  regTypesPkg::regData_t rfData   [2*`RR_LANES];
  regTypesPkg::regData_t srcData  [2*`RR_LANES];

  assign wb.wrValid = wbValid_i;
  assign wb.wrDest  = wbDest_i;
  assign wb.wrData  = wbData_i;

  // Read port 2*l serves source 1 of lane l, 2*l+1 source 2
  for (genvar l = 0; l < `RR_LANES; l++)
  begin : gSrcMap
    assign srcTag[2*l]   = src1Tag_i[l];
    assign srcTag[2*l+1] = src2Tag_i[l];
    assign src1Data_o[l] = srcData[2*l];
    assign src2Data_o[l] = srcData[2*l+1];
  end

  squashFilter squash
  (
    .clk              (clk),
    .fuValid_i        (fuValid_i),
    .branchMask_i     (branchMask_i),
    .ctrlVerified_i   (ctrlVerified_i),
    .ctrlMispredict_i (ctrlMispredict_i),
    .ctrlCkpt_i       (ctrlCkpt_i),
    .laneLive_o       (laneLive)
  );

  physRegFile regFile
  (
    .clk           (clk),
    .recoverFlag_i (recoverFlag_i),
    .wb            (wb),
    .rdTag_i       (srcTag),
    .rdData_o      (rfData)
  );

  operandSelect opSel
  (
    .clk        (clk),
    .rst_i      (rst_i),
    .wb         (wb),
    .laneLive_i (laneLive),
    .srcTag_i   (srcTag),
    .rfData_i   (rfData),
    .destTag_i  (destTag_i),
    .payload_i  (payload_i),
    .fuValid_o  (fuValid_o),
    .srcData_o  (srcData),
    .destTag_o  (destTag_o),
    .payload_o  (payload_o)
  );

  readyTable rdyTable
  (
    .clk             (clk),
    .rst_i           (rst_i),
    .exceptionFlag_i (exceptionFlag_i),
    .unmapValid_i    (unmapValid_i),
    .unmapTag_i      (unmapTag_i),
    .wakeValid_i     (wakeValid_i),
    .wakeTag_i       (wakeTag_i),
    .phyRegRdy_o     (phyRegRdy_o)
  );

endmodule

`default_nettype wire

/* verif/clkGen.sv */
`timescale 1ns/100ps
`default_nettype none

module clkGen
(
  output logic clk_o,
  output logic rst_o
);

  initial
  begin
    clk_o = 1'b0;
    forever
    begin
      #20 clk_o = ~clk_o;  // 40 ns period
    end
  end

  initial
  begin
    rst_o = 1'b1;
    repeat (16) @(posedge clk_o);
    rst_o <= 1'b0;  // Released on an edge, synchronous to the design
  end

endmodule

`default_nettype wire

/* verif/regReadChecker.sv */
`timescale 1ns/100ps
`default_nettype none
`include "regRead_params.svh"

module regReadChecker
(
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   recoverFlag_i,
  input  logic                   exceptionFlag_i,
  input  logic                   ctrlVerified_i,
  input  logic                   ctrlMispredict_i,
  input  branchPkg::ckptId_t     ctrlCkpt_i,
  input  logic                   fuValid_i    [`RR_LANES],
  input  branchPkg::branchMask_t branchMask_i [`RR_LANES],
  input  regTypesPkg::regTag_t   src1Tag_i    [`RR_LANES],
  input  regTypesPkg::regTag_t   src2Tag_i    [`RR_LANES],
  input  regTypesPkg::regTag_t   destTag_i    [`RR_LANES],
  input  regTypesPkg::payload_t  payload_i    [`RR_LANES],
  input  logic                   wbValid_i    [`RR_LANES],
  input  regTypesPkg::regTag_t   wbDest_i     [`RR_LANES],
  input  regTypesPkg::regData_t  wbData_i     [`RR_LANES],
  input  logic                   unmapValid_i [`RR_LANES],
  input  regTypesPkg::regTag_t   unmapTag_i   [`RR_LANES],
  input  logic                   wakeValid_i  [`RR_LANES],
  input  regTypesPkg::regTag_t   wakeTag_i    [`RR_LANES],
  // Observed DUT outputs
  input  logic                   fuValidOut_i [`RR_LANES],
  input  regTypesPkg::regData_t  src1Data_i   [`RR_LANES],
  input  regTypesPkg::regData_t  src2Data_i   [`RR_LANES],
  input  regTypesPkg::regTag_t   destTagOut_i [`RR_LANES],
  input  regTypesPkg::payload_t  payloadOut_i [`RR_LANES],
  input  regTypesPkg::readyVec_t phyRegRdy_i,
  output int                     errCount_o,
  output int                     checkCount_o
);

  regTypesPkg::regData_t  shadowRf    [`RR_PHYS_REGS];
  logic                   shadowKnown [`RR_PHYS_REGS];  // Written at least once
  regTypesPkg::readyVec_t shadowRdy;

  logic                  expValid   [`RR_LANES];
  regTypesPkg::regData_t expSrc1    [`RR_LANES];
  regTypesPkg::regData_t expSrc2    [`RR_LANES];
  logic                  src1Known  [`RR_LANES];
  logic                  src2Known  [`RR_LANES];
  regTypesPkg::regTag_t  expDest    [`RR_LANES];
  regTypesPkg::payload_t expPayload [`RR_LANES];
  logic                  armed;

  initial
  begin
    errCount_o   = 0;
    checkCount_o = 0;
    armed        = 1'b0;
    for (int r = 0; r < `RR_PHYS_REGS; r++)
    begin
      shadowKnown[r] = 1'b0;
    end
  end

  function automatic logic expectLive(input int lane);
    logic squash;
    squash = ctrlVerified_i && ctrlMispredict_i && branchMask_i[lane][ctrlCkpt_i];
    return fuValid_i[lane] && !squash;
  endfunction

  function automatic logic fwdHit(input regTypesPkg::regTag_t tag);
    logic hit;
    hit = 1'b0;
    for (int l = 0; l < `RR_LANES; l++)
    begin
      if (wbValid_i[l] && (wbDest_i[l] == tag))
      begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // Later matching lanes overwrite earlier ones
  function automatic regTypesPkg::regData_t operandValue(input regTypesPkg::regTag_t tag);
    regTypesPkg::regData_t value;
    value = shadowRf[tag];
    for (int l = 0; l < `RR_LANES; l++)
    begin
      if (wbValid_i[l] && (wbDest_i[l] == tag))
      begin
        value = wbData_i[l];
      end
    end
    return value;
  endfunction

  function automatic regTypesPkg::readyVec_t nextReady(input regTypesPkg::readyVec_t cur);
    regTypesPkg::readyVec_t nxt;
    nxt = cur;
    for (int l = 0; l < `RR_LANES; l++)
    begin
      if (unmapValid_i[l])
      begin
        nxt[unmapTag_i[l]] = 1'b0;
      end
    end
    for (int l = 0; l < `RR_LANES; l++)
    begin
      if (wakeValid_i[l])
      begin
        nxt[wakeTag_i[l]] = 1'b1;  // Set beats clear
      end
    end
    if (rst_i || exceptionFlag_i)
    begin
      for (int r = 0; r < `RR_PHYS_REGS; r++)
      begin
        nxt[r] = (r < `RR_ARCH_REGS);
      end
    end
    return nxt;
  endfunction

  task automatic checkValue(input string sigName, input logic [63:0] expVal,
                            input logic [63:0] gotVal);
    checkCount_o++;
    if (gotVal !== expVal)
    begin
      errCount_o++;
      $display("ERR %s expected %h got %h at %0t", sigName, expVal, gotVal, $time);
    end
  endtask

  task automatic compareOutputs();
    for (int l = 0; l < `RR_LANES; l++)
    begin
      checkValue($sformatf("fuValid_o[%0d]", l), expValid[l], fuValidOut_i[l]);
      if (expValid[l])
      begin
        checkValue($sformatf("destTag_o[%0d]", l), expDest[l], destTagOut_i[l]);
        checkValue($sformatf("payload_o[%0d]", l), expPayload[l], payloadOut_i[l]);
        if (src1Known[l])
        begin
          checkValue($sformatf("src1Data_o[%0d]", l), expSrc1[l], src1Data_i[l]);
        end
        if (src2Known[l])
        begin
          checkValue($sformatf("src2Data_o[%0d]", l), expSrc2[l], src2Data_i[l]);
        end
      end
    end
    checkValue("phyRegRdy_o", shadowRdy, phyRegRdy_i);
  endtask

  // Inputs are steady at the falling edge, outputs hold the last rising edge
  always @(negedge clk)
  begin
    if (armed)
    begin
      compareOutputs();
    end
    for (int l = 0; l < `RR_LANES; l++)
    begin
      expValid[l]   = !rst_i && expectLive(l);
      expSrc1[l]    = operandValue(src1Tag_i[l]);
      expSrc2[l]    = operandValue(src2Tag_i[l]);
      src1Known[l]  = fwdHit(src1Tag_i[l]) || shadowKnown[src1Tag_i[l]];
      src2Known[l]  = fwdHit(src2Tag_i[l]) || shadowKnown[src2Tag_i[l]];
      expDest[l]    = destTag_i[l];
      expPayload[l] = payload_i[l];
    end
    shadowRdy = nextReady(shadowRdy);
    if (!recoverFlag_i)
    begin
      for (int l = 0; l < `RR_LANES; l++)
      begin
        if (wbValid_i[l])
        begin
          shadowRf[wbDest_i[l]]    = wbData_i[l];
          shadowKnown[wbDest_i[l]] = 1'b1;
        end
      end
    end
    armed = 1'b1;
  end

endmodule

`default_nettype wire

/* verif/tb_regRead.sv */
`timescale 1ns/100ps
`default_nettype none
`include "regRead_params.svh"

module tb_regRead;

  logic                   clk;
  logic                   rst;
  logic                   recoverFlag;
  logic                   exceptionFlag;
  logic                   ctrlVerified;
  logic                   ctrlMispredict;
  branchPkg::ckptId_t     ctrlCkpt;
  logic                   fuValid    [`RR_LANES];
  branchPkg::branchMask_t branchMask [`RR_LANES];
  regTypesPkg::regTag_t   src1Tag    [`RR_LANES];
  regTypesPkg::regTag_t   src2Tag    [`RR_LANES];
  regTypesPkg::regTag_t   destTag    [`RR_LANES];
  regTypesPkg::payload_t  payload    [`RR_LANES];
  logic                   wbValid    [`RR_LANES];
  regTypesPkg::regTag_t   wbDest     [`RR_LANES];
  regTypesPkg::regData_t  wbData     [`RR_LANES];
  logic                   unmapValid [`RR_LANES];
  regTypesPkg::regTag_t   unmapTag   [`RR_LANES];
  logic                   wakeValid  [`RR_LANES];
  regTypesPkg::regTag_t   wakeTag    [`RR_LANES];
  logic                   fuValidOut [`RR_LANES];
  regTypesPkg::regData_t  src1Data   [`RR_LANES];
  regTypesPkg::regData_t  src2Data   [`RR_LANES];
  regTypesPkg::regTag_t   destTagOut [`RR_LANES];
  regTypesPkg::payload_t  payloadOut [`RR_LANES];
  regTypesPkg::readyVec_t phyRegRdy;
  int                     errCount;
  int                     checkCount;
  int                     timeoutCount;

  clkGen clockGen
  (
    .clk_o (clk),
    .rst_o (rst)
  );

  regReadStage DUT
  (
    .clk              (clk),
    .rst_i            (rst),
    .recoverFlag_i    (recoverFlag),
    .exceptionFlag_i  (exceptionFlag),
    .ctrlVerified_i   (ctrlVerified),
    .ctrlMispredict_i (ctrlMispredict),
    .ctrlCkpt_i       (ctrlCkpt),
    .fuValid_i        (fuValid),
    .branchMask_i     (branchMask),
    .src1Tag_i        (src1Tag),
    .src2Tag_i        (src2Tag),
    .destTag_i        (destTag),
    .payload_i        (payload),
    .wbValid_i        (wbValid),
    .wbDest_i         (wbDest),
    .wbData_i         (wbData),
    .unmapValid_i     (unmapValid),
    .unmapTag_i       (unmapTag),
    .wakeValid_i      (wakeValid),
    .wakeTag_i        (wakeTag),
    .fuValid_o        (fuValidOut),
    .src1Data_o       (src1Data),
    .src2Data_o       (src2Data),
    .destTag_o        (destTagOut),
    .payload_o        (payloadOut),
    .phyRegRdy_o      (phyRegRdy)
  );

  regReadChecker check
  (
    .clk              (clk),
    .rst_i            (rst),
    .recoverFlag_i    (recoverFlag),
    .exceptionFlag_i  (exceptionFlag),
    .ctrlVerified_i   (ctrlVerified),
    .ctrlMispredict_i (ctrlMispredict),
    .ctrlCkpt_i       (ctrlCkpt),
    .fuValid_i        (fuValid),
    .branchMask_i     (branchMask),
    .src1Tag_i        (src1Tag),
    .src2Tag_i        (src2Tag),
    .destTag_i        (destTag),
    .payload_i        (payload),
    .wbValid_i        (wbValid),
    .wbDest_i         (wbDest),
    .wbData_i         (wbData),
    .unmapValid_i     (unmapValid),
    .unmapTag_i       (unmapTag),
    .wakeValid_i      (wakeValid),
    .wakeTag_i        (wakeTag),
    .fuValidOut_i     (fuValidOut),
    .src1Data_i       (src1Data),
    .src2Data_i       (src2Data),
    .destTagOut_i     (destTagOut),
    .payloadOut_i     (payloadOut),
    .phyRegRdy_i      (phyRegRdy),
    .errCount_o       (errCount),
    .checkCount_o     (checkCount)
  );

  // Narrow mode crowds tags into a few registers to provoke hits and collisions
  function automatic regTypesPkg::regTag_t pickTag(input logic narrow);
    return narrow ? regTypesPkg::regTag_t'($urandom % 8) : regTypesPkg::regTag_t'($urandom);
  endfunction

  // Architectural registers ready, the rest not
  function automatic regTypesPkg::readyVec_t resetReadyPattern();
    regTypesPkg::readyVec_t pattern;
    for (int r = 0; r < `RR_PHYS_REGS; r++)
    begin
      pattern[r] = (r < `RR_ARCH_REGS);
    end
    return pattern;
  endfunction

  task automatic clearInputs();
    recoverFlag    <= 1'b0;
    exceptionFlag  <= 1'b0;
    ctrlVerified   <= 1'b0;
    ctrlMispredict <= 1'b0;
    ctrlCkpt       <= '0;
    for (int l = 0; l < `RR_LANES; l++)
    begin
      fuValid[l]    <= 1'b0;
      branchMask[l] <= '0;
      src1Tag[l]    <= '0;
      src2Tag[l]    <= '0;
      destTag[l]    <= '0;
      payload[l]    <= '0;
      wbValid[l]    <= 1'b0;
      wbDest[l]     <= '0;
      wbData[l]     <= '0;
      unmapValid[l] <= 1'b0;
      unmapTag[l]   <= '0;
      wakeValid[l]  <= 1'b0;
      wakeTag[l]    <= '0;
    end
  endtask

  // Every register gets a known value before random traffic starts
  task automatic fillRegisters();
    for (int c = 0; c < `RR_PHYS_REGS / `RR_LANES; c++)
    begin
      @(posedge clk);
      for (int l = 0; l < `RR_LANES; l++)
      begin
        wbValid[l] <= 1'b1;
        wbDest[l]  <= regTypesPkg::regTag_t'(c * `RR_LANES + l);
        wbData[l]  <= $urandom;
      end
    end
  endtask

  task automatic driveRandomCycle();
    logic narrow;
    @(posedge clk);
    narrow = ($urandom % 2) == 0;
    recoverFlag    <= ($urandom % 8) == 0;
    exceptionFlag  <= ($urandom % 50) == 0;
    ctrlVerified   <= ($urandom % 4) == 0;
    ctrlMispredict <= ($urandom % 2) == 0;
    ctrlCkpt       <= branchPkg::ckptId_t'($urandom);
    for (int l = 0; l < `RR_LANES; l++)
    begin
      fuValid[l]    <= ($urandom % 4) != 0;
      branchMask[l] <= branchPkg::branchMask_t'($urandom);
      src1Tag[l]    <= pickTag(narrow);
      src2Tag[l]    <= pickTag(narrow);
      destTag[l]    <= pickTag(1'b0);
      payload[l]    <= regTypesPkg::payload_t'($urandom);
      wbValid[l]    <= ($urandom % 2) == 0;
      wbDest[l]     <= pickTag(narrow);
      wbData[l]     <= $urandom;
      unmapValid[l] <= ($urandom % 3) == 0;
      unmapTag[l]   <= pickTag(narrow);
      wakeValid[l]  <= ($urandom % 3) == 0;
      wakeTag[l]    <= pickTag(narrow);
    end
  endtask

  task automatic waitResetRelease();
    int cycles;
    cycles = 0;
    while (rst && cycles < 100)
    begin
      @(posedge clk);
      cycles++;
    end
    if (rst)
    begin
      $display("Timeout: reset was never released");
      timeoutCount++;
    end
  endtask

  task automatic waitReadyPattern();
    int cycles;
    cycles = 0;
    while ((phyRegRdy !== resetReadyPattern()) && cycles < 20)
    begin
      @(posedge clk);
      cycles++;
    end
    if (phyRegRdy !== resetReadyPattern())
    begin
      $display("Timeout: ready table did not return to its reset pattern");
      timeoutCount++;
    end
  endtask

  task automatic printCounts();
    $display("Checks %0d, mismatches %0d, timeouts %0d", checkCount, errCount, timeoutCount);
  endtask

  initial
  begin
    void'($urandom(32'hdae));
    timeoutCount = 0;
    clearInputs();
    waitResetRelease();
    fillRegisters();
    repeat (400)
    begin
      driveRandomCycle();
    end
    @(posedge clk);
    clearInputs();
    exceptionFlag <= 1'b1;
    @(posedge clk);
    exceptionFlag <= 1'b0;
    waitReadyPattern();
    repeat (2) @(posedge clk);  // Let the checker see the last results
    printCounts();
    if (errCount == 0 && timeoutCount == 0 && checkCount > 0)
    begin
      $display("Simulation passed");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial
  begin
    #100000;
    $display("Timeout: run did not finish within its time limit");
    timeoutCount++;
    printCounts();
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
logic/regTypesPkg.sv
logic/branchPkg.sv
logic/wbBus_if.sv
logic/squashFilter.sv
logic/physRegFile.sv
logic/operandSelect.sv
logic/readyTable.sv
logic/regReadStage.sv
verif/clkGen.sv
verif/regReadChecker.sv
verif/tb_regRead.sv

/* Bender.yml */
package:
  name: regReadStage

export_include_dirs:
  - include

sources:
  - logic/regTypesPkg.sv
  - logic/branchPkg.sv
  - logic/wbBus_if.sv
  - logic/squashFilter.sv
  - logic/physRegFile.sv
  - logic/operandSelect.sv
  - logic/readyTable.sv
  - logic/regReadStage.sv
  - target: test
    files:
      - verif/clkGen.sv
      - verif/regReadChecker.sv
      - verif/tb_regRead.sv
